//--- dv/board_mgmt_assert.sv
`timescale 1ns/1ps

module board_mgmt_assert (
    input logic                         cfgmclk_int,
    input logic                         gt_tx_reset,
    input logic                         qsfp_refclk_reset,
    input logic                         sys_reset,
    input board_mgmt_pkg::led_vec_t     led,
    input board_mgmt_pkg::reset_state_t state
);

    // Clock generator always leaves reset before the system
    refclk_before_sys: assert property (@(posedge cfgmclk_int) disable iff (gt_tx_reset)
        qsfp_refclk_reset |-> sys_reset)
        else $error("sys_reset low while qsfp_refclk_reset is high");

    // LEDs stay dark while the board is held in reset
    led_dark_in_reset: assert property (@(posedge cfgmclk_int) disable iff (gt_tx_reset)
        sys_reset |-> (led == '0))
        else $error("led nonzero while sys_reset is high");

    legal_seq_state: assert property (@(posedge cfgmclk_int) disable iff (gt_tx_reset)
        state inside {board_mgmt_pkg::refclk_hold, board_mgmt_pkg::sys_hold,
                      board_mgmt_pkg::running})
        else $error("sequencer state outside reset_state_t");

endmodule

bind board_mgmt_top board_mgmt_assert board_mgmt_assert_inst (
    .cfgmclk_int       (cfgmclk_int),
    .gt_tx_reset       (gt_tx_reset),
    .qsfp_refclk_reset (qsfp_refclk_reset),
    .sys_reset         (sys_reset),
    .led               (led),
    .state             (board_reset_sequencer_inst.state)
);

//--- dv/board_mgmt_tb.sv
`timescale 1ns/1ps

`include "board_mgmt_macros.svh"

module board_mgmt_tb;

    logic                     cfgmclk_int;
    logic                     gt_tx_reset;
    logic                     reset;
    board_mgmt_pkg::sw_vec_t  sw;
    logic                     uart_txd;
    board_mgmt_pkg::led_vec_t led;
    logic                     uart_rxd;
    logic                     qsfp_refclk_reset;
    logic                     sys_reset;
    logic [31:0]              lcg_state = 32'h9fbb2ad6;

    board_mgmt_top board_mgmt_top_inst (
        .cfgmclk_int       (cfgmclk_int),
        .gt_tx_reset       (gt_tx_reset),
        .reset             (reset),
        .sw                (sw),
        .uart_txd          (uart_txd),
        .led               (led),
        .uart_rxd          (uart_rxd),
        .qsfp_refclk_reset (qsfp_refclk_reset),
        .sys_reset         (sys_reset)
    );

    initial cfgmclk_int = 1'b0;
    always #50 cfgmclk_int = ~cfgmclk_int;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic next_edge();
        @(posedge cfgmclk_int);
        #1;
    endtask

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "board_mgmt_tb stopped on first failure");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_fail($sformatf("error: %s expected %0h actual %0h",
                                  test_name, expected, actual));
        end
    endtask

    // Edges from now until the selected reset output drops
    task automatic measure_release(input bit use_sys, output int edges);
        logic level;
        edges = 0;
        forever begin
            next_edge();
            edges++;
            level = use_sys ? sys_reset : qsfp_refclk_reset;
            if (!level) break;
            if (edges > 4 * 1024) begin
                report_fail(use_sys ? "timeout: sys_reset never fell"
                                    : "timeout: qsfp_refclk_reset never fell");
            end
        end
    endtask

    task automatic check_sequence(input string test_name);
        int edges;
        check_value(test_name, 32'h3, 32'({qsfp_refclk_reset, sys_reset}));
        measure_release(1'b0, edges);
        check_value(test_name, 32'd1024, 32'(edges));
        measure_release(1'b1, edges);
        check_value(test_name, 32'd1024, 32'(edges));
    endtask

    task automatic hold_led(input string test_name, input logic [2:0] expected, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            next_edge();
            check_value(test_name, 32'(expected), 32'(led));
        end
    endtask

    task automatic test_power_up();
        repeat (10) next_edge();
        check_value("power-up", 32'h0, 32'(led));
        check_value("power-up", 32'h1, 32'(uart_rxd));
        gt_tx_reset = 1'b0;
        check_sequence("power-up");
    endtask

    task automatic test_button_restart();
        reset = 1'b0;
        next_edge();
        check_value("button restart", 32'h3, 32'({qsfp_refclk_reset, sys_reset}));
        repeat (3) next_edge();
        reset = 1'b1;
        check_sequence("button restart");
    endtask

    task automatic test_switches();
        logic [31:0] word;
        logic [2:0]  expected;
        logic [2:0]  prev_led;
        int          cycles;
        // Let core_reset clear the board logic
        repeat (`SYNC_STAGES + 2) next_edge();
        prev_led = led;
        for (int n = 0; n < 6; n++) begin
            word = lcg_next();
            sw = word[31:28];
            expected = word[30:28];
            cycles = 0;
            while (led !== expected) begin
                // Until the new pattern lands the old one must stay
                check_value("switches to leds", 32'(prev_led), 32'(led));
                next_edge();
                cycles++;
                if (cycles > (`DEBOUNCE_SAMPLES + 1) * `DEBOUNCE_RATE + 2) begin
                    report_fail("timeout: led never matched the debounced switches");
                end
            end
            if (expected != prev_led) begin
                check_value("switches latency", 32'h1,
                            32'(cycles >= (`DEBOUNCE_SAMPLES - 1) * `DEBOUNCE_RATE));
            end
            prev_led = expected;
        end
        // Switch 3 has no LED
        sw = sw ^ 4'b1000;
        hold_led("switch 3 hidden", prev_led, (`DEBOUNCE_SAMPLES + 2) * `DEBOUNCE_RATE);
    endtask

    task automatic test_glitch();
        logic [31:0]             word;
        logic [2:0]              old_led;
        board_mgmt_pkg::sw_vec_t steady;
        int                      bit_idx;
        old_led = led;
        steady = sw;
        word = lcg_next();
        bit_idx = int'(word % 32'd3);
        sw = steady ^ (4'b0001 << bit_idx);
        for (int i = 0; i < (`DEBOUNCE_SAMPLES + 2) * `DEBOUNCE_RATE; i++) begin
            if (i == `DEBOUNCE_RATE - 4) sw = steady;
            next_edge();
            check_value("glitch rejection", 32'(old_led), 32'(led));
        end
    endtask

    task automatic test_uart_loopback();
        logic [31:0] word;
        logic        tx_bit;
        int          edges;
        for (int n = 0; n < 16; n++) begin
            word = lcg_next();
            tx_bit = word[31];
            uart_txd = tx_bit;
            edges = 0;
            do begin
                next_edge();
                edges++;
                if (uart_rxd !== tx_bit && edges >= 3) begin
                    report_fail("timeout: uart_rxd did not follow uart_txd within 3 edges");
                end
            end while (uart_rxd !== tx_bit);
            // Output keeps the bit for the rest of its slot
            while (edges < 4) begin
                next_edge();
                edges++;
                check_value("uart loopback", 32'(tx_bit), 32'(uart_rxd));
            end
        end
    endtask

    initial begin
        gt_tx_reset = 1'b1;
        reset = 1'b1;
        sw = '0;
        uart_txd = 1'b1;
        test_power_up();
        test_button_restart();
        test_switches();
        test_glitch();
        test_uart_loopback();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- hdl/board_io.sv
`timescale 1ns/1ps

`include "board_mgmt_macros.svh"

module board_io (
    input  logic                     cfgmclk_int,
    input  logic                     core_reset,
    input  board_mgmt_pkg::sw_vec_t  sw,
    input  logic                     uart_txd,
    output board_mgmt_pkg::led_vec_t led,
    output logic                     uart_rxd
);

    board_mgmt_pkg::sw_vec_t sw_stable;
    logic                    uart_meta;

    switch_debouncer #(
        .rate    (`DEBOUNCE_RATE),
        .samples (`DEBOUNCE_SAMPLES)
    ) switch_debouncer_inst (
        .cfgmclk_int (cfgmclk_int),
        .core_reset  (core_reset),
        .sw          (sw),
        .sw_stable   (sw_stable)
    );

    // Only the low switches have an LED, the top one is dropped
    always_ff @(posedge cfgmclk_int or posedge core_reset) begin
        if (core_reset) begin
            led <= '0;
        end else begin
            led <= sw_stable[`LED_WIDTH-1:0];
        end
    end

    // UART loopback, idle line is high
    always_ff @(posedge cfgmclk_int or posedge core_reset) begin
        if (core_reset) begin
            uart_meta <= 1'b1;
            uart_rxd  <= 1'b1;
        end else begin
            uart_meta <= uart_txd;
            uart_rxd  <= uart_meta;
        end
    end

endmodule

//--- hdl/board_mgmt_macros.svh
`ifndef BOARD_MGMT_MACROS_SVH
`define BOARD_MGMT_MACROS_SVH

// Board GPIO widths
`define SW_WIDTH 4
`define LED_WIDTH 3

// Each sequencer phase lasts one full wrap of this timer
`define RESET_TIMER_WIDTH 10

// Switch sampling period in clock cycles
`define DEBOUNCE_RATE 16

// Equal samples needed before a switch output changes
`define DEBOUNCE_SAMPLES 4

// Flops in the reset synchronizer chain
`define SYNC_STAGES 4

`endif

//--- hdl/board_mgmt_pkg.sv
`include "board_mgmt_macros.svh"

package board_mgmt_pkg;

    // Reset sequencer states
    typedef enum logic [1:0] {
        refclk_hold = 2'd0,
        sys_hold    = 2'd1,
        running     = 2'd2
    } reset_state_t;

    // Raw and debounced DIP switches
    typedef logic [`SW_WIDTH-1:0] sw_vec_t;

    // Front panel LEDs
    typedef logic [`LED_WIDTH-1:0] led_vec_t;

endpackage

//--- hdl/board_mgmt_top.sv
`timescale 1ns/1ps

`include "board_mgmt_macros.svh"

module board_mgmt_top (
    input  logic                     cfgmclk_int,
    input  logic                     gt_tx_reset,
    input  logic                     reset,
    input  board_mgmt_pkg::sw_vec_t  sw,
    input  logic                     uart_txd,
    output board_mgmt_pkg::led_vec_t led,
    output logic                     uart_rxd,
    output logic                     qsfp_refclk_reset,
    output logic                     sys_reset
);

    // Board logic reset, follows sys_reset
    logic core_reset;

    // Power-up release order for the clock generator and the system
    board_reset_sequencer board_reset_sequencer_inst (
        .cfgmclk_int       (cfgmclk_int),
        .gt_tx_reset       (gt_tx_reset),
        .reset             (reset),
        .qsfp_refclk_reset (qsfp_refclk_reset),
        .sys_reset         (sys_reset)
    );

    reset_synchronizer #(
        .stages (`SYNC_STAGES)
    ) reset_synchronizer_inst (
        .cfgmclk_int (cfgmclk_int),
        .gt_tx_reset (gt_tx_reset),
        .rst         (sys_reset),
        .core_reset  (core_reset)
    );

    // Switches, LEDs and UART loopback
    board_io board_io_inst (
        .cfgmclk_int (cfgmclk_int),
        .core_reset  (core_reset),
        .sw          (sw),
        .uart_txd    (uart_txd),
        .led         (led),
        .uart_rxd    (uart_rxd)
    );

endmodule

//--- hdl/board_reset_sequencer.sv
`timescale 1ns/1ps

`include "board_mgmt_macros.svh"

module board_reset_sequencer (
    input  logic cfgmclk_int,
    input  logic gt_tx_reset,
    input  logic reset,
    output logic qsfp_refclk_reset,
    output logic sys_reset
);

    board_mgmt_pkg::reset_state_t state;
    logic [`RESET_TIMER_WIDTH-1:0] timer;

    // Clock generator comes out of reset first, the rest of the board later
    always_ff @(posedge cfgmclk_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state             <= board_mgmt_pkg::refclk_hold;
            timer             <= '0;
            qsfp_refclk_reset <= 1'b1;
            sys_reset         <= 1'b1;
        end else if (!reset) begin
            // Push button is active low and restarts the sequence
            state             <= board_mgmt_pkg::refclk_hold;
            timer             <= '0;
            qsfp_refclk_reset <= 1'b1;
            sys_reset         <= 1'b1;
        end else begin
            case (state)
                board_mgmt_pkg::refclk_hold: begin
                    if (&timer) begin
                        qsfp_refclk_reset <= 1'b0;
                        timer             <= '0;
                        state             <= board_mgmt_pkg::sys_hold;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                board_mgmt_pkg::sys_hold: begin
                    if (&timer) begin
                        sys_reset <= 1'b0;
                        state     <= board_mgmt_pkg::running;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                board_mgmt_pkg::running: begin
                    // Sequence done, timer parks at its last value
                    timer <= timer;
                end
                default: begin
                    state             <= board_mgmt_pkg::refclk_hold;
                    timer             <= '0;
                    qsfp_refclk_reset <= 1'b1;
                    sys_reset         <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- hdl/reset_synchronizer.sv
`timescale 1ns/1ps

`include "board_mgmt_macros.svh"

module reset_synchronizer #(
    parameter int stages = `SYNC_STAGES
) (
    input  logic cfgmclk_int,
    input  logic gt_tx_reset,
    input  logic rst,
    output logic core_reset
);

    logic [stages-1:0] sync_chain;
    logic              async_rst;

    // Either source presets the whole chain at once
    assign async_rst = gt_tx_reset | rst;

    always_ff @(posedge cfgmclk_int or posedge async_rst) begin
        if (async_rst) begin
            sync_chain <= '1;
        end else begin
            // Zeros walk through, release lands stages edges later
            sync_chain <= {sync_chain[stages-2:0], 1'b0};
        end
    end

    assign core_reset = sync_chain[stages-1];

endmodule

//--- hdl/switch_debouncer.sv
`timescale 1ns/1ps

`include "board_mgmt_macros.svh"

module switch_debouncer #(
    parameter int rate    = `DEBOUNCE_RATE,
    parameter int samples = `DEBOUNCE_SAMPLES
) (
    input  logic                    cfgmclk_int,
    input  logic                    core_reset,
    input  board_mgmt_pkg::sw_vec_t sw,
    output board_mgmt_pkg::sw_vec_t sw_stable
);

    localparam int cnt_w = (rate > 1) ? $clog2(rate) : 1;

    logic [cnt_w-1:0]                  rate_cnt;
    logic                              sample_tick;
    logic [`SW_WIDTH-1:0][samples-1:0] history;

    assign sample_tick = (rate_cnt == cnt_w'(rate - 1));

    // Sample divider
    always_ff @(posedge cfgmclk_int or posedge core_reset) begin
        if (core_reset) begin
            rate_cnt <= '0;
        end else if (sample_tick) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    // One shift register per switch
    always_ff @(posedge cfgmclk_int or posedge core_reset) begin
        if (core_reset) begin
            history <= '0;
        end else if (sample_tick) begin
            for (int i = 0; i < `SW_WIDTH; i++) begin
                history[i] <= {history[i][samples-2:0], sw[i]};
            end
        end
    end

    // Output moves only on a full run of equal samples, mixed history holds
    always_ff @(posedge cfgmclk_int or posedge core_reset) begin
        if (core_reset) begin
            sw_stable <= '0;
        end else begin
            for (int i = 0; i < `SW_WIDTH; i++) begin
                if (&history[i]) begin
                    sw_stable[i] <= 1'b1;
                end else if (~|history[i]) begin
                    sw_stable[i] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- list.f
+incdir+hdl
hdl/board_mgmt_pkg.sv
hdl/board_reset_sequencer.sv
hdl/reset_synchronizer.sv
hdl/switch_debouncer.sv
hdl/board_io.sv
hdl/board_mgmt_top.sv
dv/board_mgmt_assert.sv
dv/board_mgmt_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the board management testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module board_mgmt_tb \
    --Mdir obj_dir -o board_mgmt_sim \
    -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/board_mgmt_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
else
    echo "Pass line not found in sim.log"
    exit 1
fi
